// ==== Makefile ====
# Verilator build and run for the pipelined core testbench

VERILATOR ?= verilator
TOP       ?= processor_tb
FILELIST  ?= processor.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard *.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== alu.sv ====
// ====================
// ALU
// Add, sub, logic and shifts with compare flags
// ====================
`timescale 1ns/1ns
`include "cpu_config.svh"

module alu import cpu_pkg::*; (
    input  logic [`XLEN-1:0]    a,
    input  logic [`XLEN-1:0]    b,
    input  alu_op_e             op,
    input  logic [`SHAMT_W-1:0] shamt,
    output logic [`XLEN-1:0]    result,
    output logic                not_equal,
    output logic                less_than
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLL: result = a << shamt;
            ALU_SRA: result = $signed(a) >>> shamt;   // Keeps the sign bit
            default: result = '0;
        endcase
    end

    assign not_equal = (a != b);
    assign less_than = ($signed(a) < $signed(b));  // Signed compare, a < b

    // Decoder only passes defined ops once the pipeline holds real instructions
    always_comb begin
        if (!$isunknown(op))
            assert (op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_SRA})
                else $error("alu: undefined op %0d", op);
    end

endmodule

// ==== cpu_config.svh ====
// ====================
// Core configuration
// Widths, reset PC, link register and bubble word
// ====================
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define XLEN        32          // Data and instruction width
`define REG_ADDR_W  5           // Register index width
`define NUM_REGS    32
`define SHAMT_W     5           // Shift amount field
`define IMM_W       17          // Signed immediate field
`define TARGET_W    27          // Jump target field

`define RESET_PC    32'd0
`define LINK_REG    31          // Written by jal
`define NOP_INSTR   32'h0000_0000   // Bubble, decodes as add r0

`endif

// ==== cpu_pkg.sv ====
// ====================
// Core types
// Opcodes, ALU ops and the pipeline register layouts
// ====================
`include "cpu_config.svh"

package cpu_pkg;

    typedef enum logic [4:0] {
        OP_RTYPE = 5'd0,
        OP_J     = 5'd1,
        OP_BNE   = 5'd2,
        OP_JAL   = 5'd3,
        OP_JR    = 5'd4,
        OP_ADDI  = 5'd5,
        OP_BLT   = 5'd6,
        OP_SW    = 5'd7,
        OP_LW    = 5'd8
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_e;

    typedef struct packed {
        logic                   reg_we;     // Never set for r0
        logic [`REG_ADDR_W-1:0] rd;         // Destination
        logic [`REG_ADDR_W-1:0] src_a;      // Zero when unused
        logic [`REG_ADDR_W-1:0] src_b;
        alu_op_e                alu_op;
        logic                   use_imm;
        logic                   mem_we;
        logic                   mem_re;
        logic                   jump;       // j or jal
        logic                   link;       // jal
        logic                   jr;
        logic                   bne;
        logic                   blt;
    } ctrl_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc_plus1;
        logic [`XLEN-1:0]  instr;
    } fd_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc_plus1;
        logic [`XLEN-1:0]  instr;
        logic [`XLEN-1:0]  a;
        logic [`XLEN-1:0]  b;
        ctrl_t             ctrl;
    } dx_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       result;
        logic [`XLEN-1:0]       store_data;
        logic [`REG_ADDR_W-1:0] store_src;
        ctrl_t                  ctrl;
    } xm_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  result;
        logic [`XLEN-1:0]  load_data;
        ctrl_t             ctrl;
    } mw_t;

    // Register write port, doubles as a forwarding source
    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] idx;
        logic [`XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic [`XLEN-1:0]  addr;
        logic [`XLEN-1:0]  wdata;
        logic              wren;
    } dmem_req_t;

endpackage

// ==== decode_stage.sv ====
// ====================
// Decode stage
// Register read, load-use stall, jr and the D/X register
// ====================
`timescale 1ns/1ns
`include "cpu_config.svh"

module decode_stage import cpu_pkg::*; (
    input  logic                   clock,
    input  logic                   arst_n,
    input  fd_t                    fd,
    output logic [`REG_ADDR_W-1:0] ra_a,
    output logic [`REG_ADDR_W-1:0] ra_b,
    input  logic [`XLEN-1:0]       rd_a,
    input  logic [`XLEN-1:0]       rd_b,
    input  wb_t                    x_fwd,
    input  wb_t                    m_fwd,
    input  wb_t                    w_fwd,
    input  logic                   branch_redirect,
    output logic                   stall,
    output logic                   jr_redirect,
    output logic [`XLEN-1:0]       jr_target,
    output dx_t                    dx
);

    ctrl_t d_ctrl;
    logic  load_hit;

    instr_decoder d_dec_i (.instr(fd.instr), .ctrl(d_ctrl));

    assign ra_a = d_ctrl.src_a;
    assign ra_b = d_ctrl.src_b;

    // Load now in execute, its data is not ready for this instruction yet
    assign load_hit = dx.valid && dx.ctrl.mem_re && dx.ctrl.reg_we &&
                      (dx.ctrl.rd == d_ctrl.src_a || dx.ctrl.rd == d_ctrl.src_b);
    assign stall    = load_hit;     // An empty slot holds the bubble word, which reads only r0

    // jr target, newest producer wins
    always_comb begin
        if (x_fwd.en && x_fwd.idx == d_ctrl.src_b)      jr_target = x_fwd.data;
        else if (m_fwd.en && m_fwd.idx == d_ctrl.src_b) jr_target = m_fwd.data;
        else if (w_fwd.en && w_fwd.idx == d_ctrl.src_b) jr_target = w_fwd.data;
        else                                            jr_target = rd_b;
    end

    assign jr_redirect = d_ctrl.jr && !stall && !branch_redirect;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dx <= '0;
        end else if (stall || branch_redirect || !fd.valid) begin
            dx       <= '0;           // Bubble
            dx.instr <= `NOP_INSTR;
        end else begin
            dx.valid    <= 1'b1;
            dx.pc_plus1 <= fd.pc_plus1;
            dx.instr    <= fd.instr;
            dx.a        <= rd_a;
            dx.b        <= rd_b;
            dx.ctrl     <= d_ctrl;
        end
    end

    a_ctl_needs_fd: assert property (@(posedge clock) disable iff (!arst_n)
        (stall || jr_redirect) |-> fd.valid);

endmodule

// ==== execute_stage.sv ====
// ====================
// Execute stage
// Forwarding, ALU, branch decision and the X/M register
// ====================
`timescale 1ns/1ns
`include "cpu_config.svh"

module execute_stage import cpu_pkg::*; (
    input  logic              clock,
    input  logic              arst_n,
    input  dx_t               dx,
    input  wb_t               m_fwd,
    input  wb_t               w_fwd,
    output wb_t               x_fwd,
    output logic              branch_redirect,
    output logic [`XLEN-1:0]  branch_target,
    output xm_t               xm
);

    logic [`XLEN-1:0] opnd_a;
    logic [`XLEN-1:0] opnd_b;       // Forwarded rt/rd value, also store data
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] imm_ext;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] result;
    logic             ne;
    logic             lt;

    // Memory stage is newer than writeback, so check it first
    always_comb begin
        if (m_fwd.en && m_fwd.idx == dx.ctrl.src_a)      opnd_a = m_fwd.data;
        else if (w_fwd.en && w_fwd.idx == dx.ctrl.src_a) opnd_a = w_fwd.data;
        else                                             opnd_a = dx.a;

        if (m_fwd.en && m_fwd.idx == dx.ctrl.src_b)      opnd_b = m_fwd.data;
        else if (w_fwd.en && w_fwd.idx == dx.ctrl.src_b) opnd_b = w_fwd.data;
        else                                             opnd_b = dx.b;
    end

    assign imm_ext = {{(`XLEN-`IMM_W){dx.instr[`IMM_W-1]}}, dx.instr[`IMM_W-1:0]};
    assign alu_b   = dx.ctrl.use_imm ? imm_ext : opnd_b;

    alu x_alu_i (
        .a         (opnd_a),
        .b         (alu_b),
        .op        (dx.ctrl.alu_op),
        .shamt     (dx.instr[11:7]),
        .result    (alu_out),
        .not_equal (ne),
        .less_than (lt)
    );

    assign result = dx.ctrl.link ? dx.pc_plus1 : alu_out;   // jal links PC+1

    // A is rs and B is rd; blt wants rd < rs
    assign branch_redirect = dx.valid &&
                             ((dx.ctrl.bne && ne) || (dx.ctrl.blt && ne && !lt));
    assign branch_target   = dx.pc_plus1 + imm_ext;

    // Load data is not known yet, decode stalls for that case
    assign x_fwd.en   = dx.valid && dx.ctrl.reg_we && !dx.ctrl.mem_re;
    assign x_fwd.idx  = dx.ctrl.rd;
    assign x_fwd.data = result;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            xm <= '0;
        end else begin
            xm.valid      <= dx.valid;
            xm.result     <= result;
            xm.store_data <= opnd_b;
            xm.store_src  <= dx.ctrl.src_b;
            xm.ctrl       <= dx.ctrl;
        end
    end

endmodule

// ==== fetch_stage.sv ====
// ====================
// Fetch stage
// PC, next-PC select and the F/D register
// ====================
`timescale 1ns/1ns
`include "cpu_config.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              stall,
    input  logic              branch_redirect,
    input  logic [`XLEN-1:0]  branch_target,
    input  logic              jr_redirect,
    input  logic [`XLEN-1:0]  jr_target,
    input  logic [`XLEN-1:0]  q_imem,
    output logic [`XLEN-1:0]  address_imem,
    output fd_t               fd
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_plus1;
    logic [`XLEN-1:0] jump_target;
    ctrl_t            f_ctrl;

    instr_decoder f_dec_i (.instr(q_imem), .ctrl(f_ctrl));  // Only jump is used here

    assign pc_plus1     = pc + 1'b1;
    assign jump_target  = {{(`XLEN-`TARGET_W){1'b0}}, q_imem[`TARGET_W-1:0]};
    assign address_imem = pc;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
            fd <= '0;
        end else begin
            if (jr_redirect)          pc <= jr_target;
            else if (branch_redirect) pc <= branch_target;
            else if (stall)           pc <= pc;
            else if (f_ctrl.jump)     pc <= jump_target;   // j/jal, no bubble
            else                      pc <= pc_plus1;

            if (jr_redirect || branch_redirect) begin
                fd <= '{valid: 1'b0, pc_plus1: '0, instr: `NOP_INSTR};
            end else if (!stall) begin
                fd <= '{valid: 1'b1, pc_plus1: pc_plus1, instr: q_imem};
            end
        end
    end

endmodule

// ==== instr_decoder.sv ====
// ====================
// Instruction decoder
// Opcode to register indices and control flags
// ====================
`timescale 1ns/1ns
`include "cpu_config.svh"

module instr_decoder import cpu_pkg::*; (
    input  logic [`XLEN-1:0] instr,
    output ctrl_t            ctrl
);

    logic [`REG_ADDR_W-1:0] f_rd;
    logic [`REG_ADDR_W-1:0] f_rs;
    logic [`REG_ADDR_W-1:0] f_rt;
    logic                   we;

    assign f_rd = instr[26:22];
    assign f_rs = instr[21:17];
    assign f_rt = instr[16:12];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        we          = 1'b0;
        case (opcode_e'(instr[31:27]))
            OP_RTYPE: begin
                we          = 1'b1;
                ctrl.rd     = f_rd;
                ctrl.src_a  = f_rs;
                ctrl.src_b  = f_rt;
                ctrl.alu_op = alu_op_e'(instr[6:2]);
            end
            OP_ADDI, OP_LW: begin
                we           = 1'b1;
                ctrl.rd      = f_rd;
                ctrl.src_a   = f_rs;
                ctrl.use_imm = 1'b1;
                ctrl.mem_re  = (instr[31:27] == OP_LW);
            end
            OP_SW: begin
                ctrl.src_a   = f_rs;
                ctrl.src_b   = f_rd;      // Store data comes from rd
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = 1'b1;
            end
            OP_BNE, OP_BLT: begin
                ctrl.src_a = f_rs;
                ctrl.src_b = f_rd;
                ctrl.bne   = (instr[31:27] == OP_BNE);
                ctrl.blt   = (instr[31:27] == OP_BLT);
            end
            OP_J:   ctrl.jump = 1'b1;
            OP_JAL: begin
                we        = 1'b1;
                ctrl.rd   = `REG_ADDR_W'(`LINK_REG);
                ctrl.jump = 1'b1;
                ctrl.link = 1'b1;
            end
            OP_JR: begin
                ctrl.src_b = f_rd;        // Target register travels on port B
                ctrl.jr    = 1'b1;
            end
            default: ;
        endcase
        ctrl.reg_we = we && (ctrl.rd != '0);    // r0 stays zero
    end

endmodule

// ==== mem_wb_stage.sv ====
// ====================
// Memory and writeback stages
// Data memory request, M/W register, writeback select
// ====================
`timescale 1ns/1ns
`include "cpu_config.svh"

module mem_wb_stage import cpu_pkg::*; (
    input  logic              clock,
    input  logic              arst_n,
    input  xm_t               xm,
    input  logic [`XLEN-1:0]  q_dmem,
    output dmem_req_t         dmem_req,
    output wb_t               m_fwd,
    output wb_t               wb
);

    mw_t mw;

    assign dmem_req.addr  = xm.result;
    assign dmem_req.wdata = (wb.en && wb.idx == xm.store_src) ? wb.data : xm.store_data;
    assign dmem_req.wren  = xm.ctrl.mem_we;     // Bubbles carry cleared controls

    // A load in this stage already has its data from the combinational read
    assign m_fwd.en   = xm.valid && xm.ctrl.reg_we;
    assign m_fwd.idx  = xm.ctrl.rd;
    assign m_fwd.data = xm.ctrl.mem_re ? q_dmem : xm.result;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            mw <= '0;
        end else begin
            mw.valid     <= xm.valid;
            mw.result    <= xm.result;
            mw.load_data <= q_dmem;
            mw.ctrl      <= xm.ctrl;
        end
    end

    assign wb.en   = mw.valid && mw.ctrl.reg_we;
    assign wb.idx  = mw.ctrl.rd;
    assign wb.data = mw.ctrl.mem_re ? mw.load_data : mw.result;

    a_wren_valid: assert property (@(posedge clock) disable iff (!arst_n)
        dmem_req.wren |-> xm.valid);

endmodule

// ==== processor.f ====
+incdir+.
cpu_pkg.sv
alu.sv
instr_decoder.sv
regfile.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_wb_stage.sv
processor.sv
processor_tb.sv

// ==== processor.sv ====
// ====================
// Five-stage pipelined core
// Stages, register file and memory ports
// ====================
`timescale 1ns/1ns
`include "cpu_config.svh"

module processor import cpu_pkg::*; (
    input  logic              clock,
    input  logic              arst_n,
    output logic [`XLEN-1:0]  address_imem,
    input  logic [`XLEN-1:0]  q_imem,
    output dmem_req_t         dmem_req,
    input  logic [`XLEN-1:0]  q_dmem,
    output wb_t               wb
);

    fd_t                    fd;
    dx_t                    dx;
    xm_t                    xm;
    wb_t                    x_fwd;
    wb_t                    m_fwd;
    logic [`REG_ADDR_W-1:0] ra_a;
    logic [`REG_ADDR_W-1:0] ra_b;
    logic [`XLEN-1:0]       rd_a;
    logic [`XLEN-1:0]       rd_b;
    logic                   stall;
    logic                   jr_redirect;
    logic [`XLEN-1:0]       jr_target;
    logic                   branch_redirect;
    logic [`XLEN-1:0]       branch_target;

    fetch_stage fetch_i (
        .clock, .arst_n, .stall,
        .branch_redirect, .branch_target,
        .jr_redirect, .jr_target,
        .q_imem, .address_imem, .fd
    );

    decode_stage decode_i (
        .clock, .arst_n, .fd,
        .ra_a, .ra_b, .rd_a, .rd_b,
        .x_fwd, .m_fwd, .w_fwd(wb),
        .branch_redirect, .stall, .jr_redirect, .jr_target, .dx
    );

    execute_stage execute_i (
        .clock, .arst_n, .dx,
        .m_fwd, .w_fwd(wb), .x_fwd,
        .branch_redirect, .branch_target, .xm
    );

    mem_wb_stage mem_wb_i (
        .clock, .arst_n, .xm, .q_dmem, .dmem_req, .m_fwd, .wb
    );

    regfile regfile_i (
        .clock, .arst_n, .ra_a, .ra_b, .rd_a, .rd_b, .wr(wb)
    );

endmodule

// ==== processor_tb.sv ====
// ====================
// Testbench for the pipelined core
// Reference ISS, ROM and RAM models, write-port checks
// ====================
`timescale 1ns/1ns
`include "cpu_config.svh"

module processor_tb import cpu_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS  = 5;
    localparam int ROM_WORDS  = 1024;
    localparam int RAM_WORDS  = 256;
    localparam int MAX_STEPS  = 500;

    logic              clock;
    logic              arst_n;
    logic [`XLEN-1:0]  address_imem;
    logic [`XLEN-1:0]  q_imem;
    dmem_req_t         dmem_req;
    logic [`XLEN-1:0]  q_dmem;
    wb_t               wb;

    logic [`XLEN-1:0]  rom [ROM_WORDS];
    logic [`XLEN-1:0]  ram [RAM_WORDS];
    logic [`XLEN-1:0]  ref_regs [`NUM_REGS];
    logic [`XLEN-1:0]  ref_mem [RAM_WORDS];
    wb_t               exp_wb [$];          // Register writes in retire order
    dmem_req_t         exp_st [$];
    int                wr_ptr;
    string             cur_test;
    logic [15:0]       lfsr;
    int                wb_errors    = 0;
    int                store_errors = 0;
    int                other_errors = 0;

    processor processor_i (
        .clock, .arst_n, .address_imem, .q_imem, .dmem_req, .q_dmem, .wb
    );

    assign q_imem = rom[address_imem[9:0]];
    assign q_dmem = arst_n ? ram[dmem_req.addr[7:0]] : '0;

    function automatic logic [`XLEN-1:0] fill_word(input int addr);
        return {16'hd00d, 8'(addr), ~8'(addr)};
    endfunction

    // Data RAM, refilled while reset is held
    always @(posedge clock) begin
        if (!arst_n) begin
            for (int i = 0; i < RAM_WORDS; i++) ram[i] <= fill_word(i);
        end else if (dmem_req.wren) begin
            ram[dmem_req.addr[7:0]] <= dmem_req.wdata;
        end
    end

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD/2) clock = ~clock;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] rtype_word(input alu_op_e op, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] sh);
        return {OP_RTYPE, rd, rs, rt, sh, op, 2'b00};
    endfunction

    function automatic logic [31:0] itype_word(input opcode_e opc, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [16:0] imm);
        return {opc, rd, rs, imm};
    endfunction

    function automatic logic [31:0] jump_word(input opcode_e opc, input logic [26:0] tgt);
        return {opc, tgt};
    endfunction

    task automatic put(input logic [31:0] word);
        rom[wr_ptr] = word;
        wr_ptr++;
    endtask

    function automatic void write_ref(input logic [4:0] idx, input logic [`XLEN-1:0] val);
        if (idx != '0) begin                // r0 never shows on the write port
            ref_regs[idx] = val;
            exp_wb.push_back('{en: 1'b1, idx: idx, data: val});
        end
    endfunction

    // Runs the program in order, one instruction at a time, until the halt jump
    task automatic run_reference();
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       ins;
        logic [`XLEN-1:0]       va;
        logic [`XLEN-1:0]       vb;
        logic [`XLEN-1:0]       vd;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       addr;
        logic [`XLEN-1:0]       res;
        logic [`REG_ADDR_W-1:0] rd;
        int                     steps;
        pc    = `RESET_PC;
        steps = 0;
        for (int i = 0; i < `NUM_REGS; i++) ref_regs[i] = '0;
        while (rom[pc[9:0]] != jump_word(OP_J, pc[26:0]) && steps < MAX_STEPS) begin
            ins  = rom[pc[9:0]];
            rd   = ins[26:22];
            va   = ref_regs[ins[21:17]];
            vb   = ref_regs[ins[16:12]];
            vd   = ref_regs[rd];
            imm  = {{(`XLEN-`IMM_W){ins[16]}}, ins[16:0]};
            addr = va + imm;
            pc   = pc + 1;
            case (opcode_e'(ins[31:27]))
                OP_RTYPE: begin
                    case (alu_op_e'(ins[6:2]))
                        ALU_ADD: res = va + vb;
                        ALU_SUB: res = va - vb;
                        ALU_AND: res = va & vb;
                        ALU_OR:  res = va | vb;
                        ALU_SLL: res = va << ins[11:7];
                        default: res = $signed(va) >>> ins[11:7];
                    endcase
                    write_ref(rd, res);
                end
                OP_ADDI: write_ref(rd, addr);
                OP_LW:   write_ref(rd, ref_mem[addr[7:0]]);
                OP_SW: begin
                    ref_mem[addr[7:0]] = vd;   // Store data comes from rd
                    exp_st.push_back('{addr: addr, wdata: vd, wren: 1'b1});
                end
                OP_J:    pc = {5'd0, ins[26:0]};
                OP_JAL: begin
                    write_ref(`REG_ADDR_W'(`LINK_REG), pc);
                    pc = {5'd0, ins[26:0]};
                end
                OP_JR:   pc = vd;
                OP_BNE:  if (vd != va) pc = pc + imm;
                OP_BLT:  if ($signed(vd) < $signed(va)) pc = pc + imm;   // rd < rs
                default: ;
            endcase
            steps++;
        end
        if (steps >= MAX_STEPS) begin
            other_errors++;
            $display("%s: reference model never reached the halt jump", cur_test);
        end
    endtask

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        if (act !== exp) begin
            wb_errors++;
            $display("FAILED %s: expected write r%0d = %h, actual en %0b r%0d = %h",
                     name, exp.idx, exp.data, act.en, act.idx, act.data);
        end
    endtask

    task automatic check_store(input string name, input dmem_req_t exp, input dmem_req_t act);
        if (act !== exp) begin
            store_errors++;
            $display("FAILED %s: expected store [%h] = %h, actual [%h] = %h",
                     name, exp.addr, exp.wdata, act.addr, act.wdata);
        end
    endtask

    // Sample the DUT in mid-cycle, when its outputs have settled
    always @(negedge clock) begin
        if (arst_n) begin
            if (wb.en) begin
                if (exp_wb.size() == 0) begin
                    other_errors++;
                    $display("%s: extra register write r%0d = %h", cur_test, wb.idx, wb.data);
                end else begin
                    check_wb(cur_test, exp_wb.pop_front(), wb);
                end
            end
            if (dmem_req.wren) begin
                if (exp_st.size() == 0) begin
                    other_errors++;
                    $display("%s: extra store to %h", cur_test, dmem_req.addr);
                end else begin
                    check_store(cur_test, exp_st.pop_front(), dmem_req);
                end
            end
        end
    end

    task automatic open_test(input string name);
        @(posedge clock);
        arst_n <= 1'b0;
        @(negedge clock);                   // Load the ROM away from the rising edge
        cur_test = name;
        for (int i = 0; i < ROM_WORDS; i++) rom[i] = `NOP_INSTR;
        for (int i = 0; i < RAM_WORDS; i++) ref_mem[i] = fill_word(i);
        wr_ptr = 0;
        exp_wb.delete();
        exp_st.delete();
    endtask

    task automatic run_and_check();
        int cycles;
        put(jump_word(OP_J, 27'(wr_ptr)));  // Halt, a jump to itself
        run_reference();
        repeat (3) @(posedge clock);
        arst_n <= 1'b1;
        cycles = 0;
        while ((exp_wb.size() != 0 || exp_st.size() != 0) && cycles < 150) begin
            @(posedge clock);
            cycles++;
        end
        if (exp_wb.size() != 0 || exp_st.size() != 0) begin
            other_errors++;
            $display("%s: %0d register writes and %0d stores never appeared",
                     cur_test, exp_wb.size(), exp_st.size());
        end
        repeat (20) @(posedge clock);       // Any write now is an extra one
        exp_wb.delete();
        exp_st.delete();
    endtask

    task automatic test_alu_chain();
        logic [`SHAMT_W-1:0] sh_left;
        logic [`SHAMT_W-1:0] sh_right;
        open_test("test_alu_chain");
        sh_left  = `SHAMT_W'(rand_bits(`SHAMT_W));
        sh_right = `SHAMT_W'(rand_bits(`SHAMT_W));
        put(itype_word(OP_ADDI, 5'd1, 5'd0, `IMM_W'(rand_bits(`IMM_W))));
        put(itype_word(OP_ADDI, 5'd2, 5'd0, `IMM_W'(rand_bits(`IMM_W))));
        put(rtype_word(ALU_ADD, 5'd3, 5'd1, 5'd2, 5'd0));  // r2 from memory, r1 from writeback
        put(rtype_word(ALU_SUB, 5'd4, 5'd3, 5'd1, 5'd0));
        put(rtype_word(ALU_AND, 5'd5, 5'd4, 5'd3, 5'd0));
        put(rtype_word(ALU_OR,  5'd6, 5'd5, 5'd4, 5'd0));
        put(rtype_word(ALU_SLL, 5'd7, 5'd6, 5'd0, sh_left));
        put(rtype_word(ALU_SRA, 5'd8, 5'd7, 5'd0, sh_right));
        put(rtype_word(ALU_SUB, 5'd9, 5'd8, 5'd6, 5'd0));
        run_and_check();
    endtask

    task automatic test_load_use();
        open_test("test_load_use");
        put(itype_word(OP_ADDI, 5'd1, 5'd0, `IMM_W'(rand_bits(`IMM_W))));
        put(itype_word(OP_ADDI, 5'd2, 5'd0, 17'd16));      // Base address
        put(itype_word(OP_SW,   5'd1, 5'd2, 17'd3));       // Data r1 comes from writeback
        put(itype_word(OP_LW,   5'd3, 5'd2, 17'd3));
        put(rtype_word(ALU_ADD, 5'd4, 5'd3, 5'd1, 5'd0));  // Load-use, one stall
        put(itype_word(OP_LW,   5'd5, 5'd2, 17'd5));       // Untouched word
        put(itype_word(OP_SW,   5'd5, 5'd2, 17'd6));
        put(itype_word(OP_LW,   5'd6, 5'd2, 17'd6));
        put(rtype_word(ALU_ADD, 5'd7, 5'd6, 5'd4, 5'd0));
        run_and_check();
    endtask

    task automatic test_branches();
        open_test("test_branches");
        put(itype_word(OP_ADDI, 5'd1,  5'd0,  17'd5));
        put(itype_word(OP_ADDI, 5'd2,  5'd0,  17'd9));
        put(itype_word(OP_BNE,  5'd1,  5'd2,  17'd2));     // Taken
        put(itype_word(OP_ADDI, 5'd3,  5'd0,  17'd111));
        put(itype_word(OP_ADDI, 5'd4,  5'd0,  17'd222));
        put(itype_word(OP_ADDI, 5'd5,  5'd0,  17'd1));
        put(itype_word(OP_BNE,  5'd1,  5'd1,  17'd1));     // Not taken
        put(itype_word(OP_ADDI, 5'd6,  5'd0,  17'd2));
        put(itype_word(OP_BLT,  5'd1,  5'd2,  17'd2));     // 5 < 9, taken
        put(itype_word(OP_ADDI, 5'd7,  5'd0,  17'd7));
        put(itype_word(OP_ADDI, 5'd8,  5'd0,  17'd8));
        put(itype_word(OP_ADDI, 5'd9,  5'd1,  17'd3));
        put(itype_word(OP_BLT,  5'd2,  5'd1,  17'd1));     // Not taken
        put(itype_word(OP_ADDI, 5'd10, 5'd0,  17'd4));
        put(itype_word(OP_ADDI, 5'd11, 5'd0,  -17'sd3));
        put(itype_word(OP_BLT,  5'd11, 5'd1,  17'd1));     // Signed, -3 < 5
        put(itype_word(OP_ADDI, 5'd12, 5'd0,  17'd12));
        put(itype_word(OP_ADDI, 5'd13, 5'd11, `IMM_W'(rand_bits(`IMM_W))));
        run_and_check();
    endtask

    task automatic test_jumps();
        open_test("test_jumps");
        put(itype_word(OP_ADDI, 5'd1, 5'd0, 17'd5));       // 0
        put(jump_word(OP_J, 27'd3));                       // 1
        put(itype_word(OP_ADDI, 5'd2, 5'd0, 17'd99));      // 2, skipped
        put(jump_word(OP_JAL, 27'd6));                     // 3, r31 = 4
        put(itype_word(OP_ADDI, 5'd3, 5'd1, 17'd1));       // 4, return point
        put(jump_word(OP_J, 27'd9));                       // 5
        put(itype_word(OP_ADDI, 5'd4, 5'd0, 17'd7));       // 6
        put(itype_word(OP_JR, 5'd31, 5'd0, 17'd0));        // 7
        put(itype_word(OP_ADDI, 5'd5, 5'd0, 17'd55));      // 8, flushed
        run_and_check();                                   // Halt lands at 9
    endtask

    task automatic test_r0();
        open_test("test_r0");
        put(itype_word(OP_ADDI, 5'd0, 5'd0, 17'd77));
        put(itype_word(OP_ADDI, 5'd1, 5'd0, `IMM_W'(rand_bits(`IMM_W))));
        put(rtype_word(ALU_ADD, 5'd0, 5'd1, 5'd1, 5'd0));
        put(rtype_word(ALU_ADD, 5'd2, 5'd1, 5'd0, 5'd0));  // r0 right after a write to it
        put(itype_word(OP_ADDI, 5'd3, 5'd0, 17'd5));
        put(rtype_word(ALU_ADD, 5'd0, 5'd3, 5'd3, 5'd0));
        put(itype_word(OP_SW,   5'd0, 5'd0, 17'd8));       // Stores zero
        put(itype_word(OP_LW,   5'd4, 5'd0, 17'd8));
        put(rtype_word(ALU_ADD, 5'd5, 5'd4, 5'd3, 5'd0));
        run_and_check();
    endtask

    initial begin
        arst_n   = 1'b0;
        lfsr     = 16'd54120;
        cur_test = "startup";
        for (int i = 0; i < ROM_WORDS; i++) rom[i] = `NOP_INSTR;
        test_alu_chain();
        test_load_use();
        test_branches();
        test_jumps();
        test_r0();
        $display("Errors: %0d register writes, %0d stores, %0d other",
                 wb_errors, store_errors, other_errors);
        if (wb_errors + store_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Each test needs well under 200 cycles
    initial begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Watchdog expired during %s, the run did not finish", cur_test);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== regfile.sv ====
// ====================
// Register file
// 32 x 32, two read ports, write-through to reads
// ====================
`timescale 1ns/1ns
`include "cpu_config.svh"

module regfile import cpu_pkg::*; (
    input  logic                   clock,
    input  logic                   arst_n,
    input  logic [`REG_ADDR_W-1:0] ra_a,
    input  logic [`REG_ADDR_W-1:0] ra_b,
    output logic [`XLEN-1:0]       rd_a,
    output logic [`XLEN-1:0]       rd_b,
    input  wb_t                    wr
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) regs[i] <= '0;
        end else if (wr.en && wr.idx != '0) begin
            regs[wr.idx] <= wr.data;
        end
    end

    // Same-cycle write shows on the read ports
    assign rd_a = (wr.en && wr.idx == ra_a && ra_a != '0) ? wr.data : regs[ra_a];
    assign rd_b = (wr.en && wr.idx == ra_b && ra_b != '0) ? wr.data : regs[ra_b];

    a_no_r0_write: assert property (@(posedge clock) disable iff (!arst_n)
        wr.en |-> wr.idx != '0);

endmodule
